//--- rtl/bus_pkg.sv
// System bus package: widths, memory map, response codes and slave state encoding
package bus_pkg;

    localparam int ADDR_BITS = 16;
    localparam int DATA_BITS = 32;
    localparam int MST_TOTAL = 2;
    localparam int SLV_TOTAL = 2;   // Default slave sits at slot SLV_TOTAL
    localparam int PAGE_BITS = 8;   // 256-byte decode pages

    // Page bounds per slave, end is exclusive
    localparam logic [SLV_TOTAL-1:0][ADDR_BITS-PAGE_BITS-1:0] SLV_MAP_START = {
        8'h10,  // Slave 1 at 0x1000
        8'h00   // Slave 0 at 0x0000
    };
    localparam logic [SLV_TOTAL-1:0][ADDR_BITS-PAGE_BITS-1:0] SLV_MAP_END = {
        8'h14,
        8'h04
    };

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Write side sequence of every slave
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WDATA = 2'd1,
        ST_BRESP = 2'd2
    } slv_state_e;

endpackage

//--- rtl/bus_xbar.sv
// Bus crossbar: master arbitration, page decode and route-steered muxing of all five channels
module bus_xbar (
    input  logic                                                  i_clk,
    input  logic                                                  i_nrst,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_ar_valid,
    input  logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::ADDR_BITS-1:0] i_ar_addr,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_ar_ready,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_r_valid,
    output logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::DATA_BITS-1:0] o_r_data,
    output logic [bus_pkg::MST_TOTAL-1:0][1:0]                    o_r_resp,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_r_ready,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_aw_valid,
    input  logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::ADDR_BITS-1:0] i_aw_addr,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_aw_ready,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_w_valid,
    input  logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::DATA_BITS-1:0] i_w_data,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_w_ready,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_b_valid,
    output logic [bus_pkg::MST_TOTAL-1:0][1:0]                    o_b_resp,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_b_ready,
    output logic [bus_pkg::SLV_TOTAL:0]                           o_s_ar_valid,
    output logic [bus_pkg::SLV_TOTAL:0][bus_pkg::ADDR_BITS-1:0]   o_s_ar_addr,
    input  logic [bus_pkg::SLV_TOTAL:0]                           i_s_ar_ready,
    input  logic [bus_pkg::SLV_TOTAL:0]                           i_s_r_valid,
    input  logic [bus_pkg::SLV_TOTAL:0][bus_pkg::DATA_BITS-1:0]   i_s_r_data,
    input  logic [bus_pkg::SLV_TOTAL:0][1:0]                      i_s_r_resp,
    output logic [bus_pkg::SLV_TOTAL:0]                           o_s_r_ready,
    output logic [bus_pkg::SLV_TOTAL:0]                           o_s_aw_valid,
    output logic [bus_pkg::SLV_TOTAL:0][bus_pkg::ADDR_BITS-1:0]   o_s_aw_addr,
    input  logic [bus_pkg::SLV_TOTAL:0]                           i_s_aw_ready,
    output logic [bus_pkg::SLV_TOTAL:0]                           o_s_w_valid,
    output logic [bus_pkg::SLV_TOTAL:0][bus_pkg::DATA_BITS-1:0]   o_s_w_data,
    input  logic [bus_pkg::SLV_TOTAL:0]                           i_s_w_ready,
    input  logic [bus_pkg::SLV_TOTAL:0]                           i_s_b_valid,
    input  logic [bus_pkg::SLV_TOTAL:0][1:0]                      i_s_b_resp,
    output logic [bus_pkg::SLV_TOTAL:0]                           o_s_b_ready
);

    localparam int MST = bus_pkg::MST_TOTAL;
    localparam int SLV = bus_pkg::SLV_TOTAL;
    localparam int MW = $clog2(MST + 1);
    localparam int SW = $clog2(SLV + 2);
    localparam logic [MW-1:0] M_IDLE = MW'(MST);
    localparam logic [SW-1:0] S_IDLE = SW'(SLV + 1);   // One past the default slave

    logic [MW-1:0] r_midx, w_midx, b_midx;
    logic [SW-1:0] r_sidx, w_sidx, b_sidx;
    logic [MW-1:0] ar_midx, aw_midx;
    logic [SW-1:0] ar_sidx, aw_sidx;
    logic ar_req, aw_req;
    logic [bus_pkg::ADDR_BITS-1:0] ar_addr, aw_addr;
    logic sel_ar_ready, sel_aw_ready, sel_r_valid, sel_r_ready;
    logic sel_w_valid, sel_w_ready, sel_b_valid, sel_b_ready;
    logic [1:0] sel_r_resp, sel_b_resp;
    logic [bus_pkg::DATA_BITS-1:0] sel_r_data, sel_w_data;
    logic r_busy, w_busy, b_busy;
    logic ar_fire, aw_fire, r_fire, w_fire, b_fire;

    // Page match against the map, unmapped pages go to the default slave
    function automatic logic [SW-1:0] decode(input logic [bus_pkg::ADDR_BITS-1:0] addr);
        logic [bus_pkg::ADDR_BITS-bus_pkg::PAGE_BITS-1:0] page;
        logic [SW-1:0] sidx;
        page = addr[bus_pkg::ADDR_BITS-1:bus_pkg::PAGE_BITS];
        sidx = SW'(SLV);
        for (int i = 0; i < SLV; i++) begin
            if (page >= bus_pkg::SLV_MAP_START[i] && page < bus_pkg::SLV_MAP_END[i]) begin
                sidx = SW'(i);
            end
        end
        return sidx;
    endfunction

    // Highest requesting master wins
    always_comb begin
        ar_midx = M_IDLE;
        aw_midx = M_IDLE;
        ar_req = 1'b0;
        aw_req = 1'b0;
        ar_addr = '0;
        aw_addr = '0;
        for (int i = 0; i < MST; i++) begin
            if (i_ar_valid[i]) begin
                ar_midx = MW'(i);
                ar_req = 1'b1;
                ar_addr = i_ar_addr[i];
            end
            if (i_aw_valid[i]) begin
                aw_midx = MW'(i);
                aw_req = 1'b1;
                aw_addr = i_aw_addr[i];
            end
        end
    end

    assign ar_sidx = decode(ar_addr);
    assign aw_sidx = decode(aw_addr);

    // Pick the signals of the routed ports
    always_comb begin
        sel_ar_ready = 1'b0;
        sel_aw_ready = 1'b0;
        sel_r_valid = 1'b0;
        sel_r_data = '0;
        sel_r_resp = '0;
        sel_w_ready = 1'b0;
        sel_b_valid = 1'b0;
        sel_b_resp = '0;
        sel_r_ready = 1'b0;
        sel_w_valid = 1'b0;
        sel_w_data = '0;
        sel_b_ready = 1'b0;
        for (int j = 0; j <= SLV; j++) begin
            if (ar_sidx == SW'(j)) sel_ar_ready = i_s_ar_ready[j];
            if (aw_sidx == SW'(j)) sel_aw_ready = i_s_aw_ready[j];
            if (w_sidx == SW'(j)) sel_w_ready = i_s_w_ready[j];
            if (r_sidx == SW'(j)) begin
                sel_r_valid = i_s_r_valid[j];
                sel_r_data = i_s_r_data[j];
                sel_r_resp = i_s_r_resp[j];
            end
            if (b_sidx == SW'(j)) begin
                sel_b_valid = i_s_b_valid[j];
                sel_b_resp = i_s_b_resp[j];
            end
        end
        for (int i = 0; i < MST; i++) begin
            if (r_midx == MW'(i)) sel_r_ready = i_r_ready[i];
            if (b_midx == MW'(i)) sel_b_ready = i_b_ready[i];
            if (w_midx == MW'(i)) begin
                sel_w_valid = i_w_valid[i];
                sel_w_data = i_w_data[i];
            end
        end
    end

    assign r_fire = sel_r_valid & sel_r_ready;
    assign b_fire = sel_b_valid & sel_b_ready;
    assign r_busy = (r_sidx != S_IDLE) & ~r_fire;   // Frees on the last read beat
    assign b_busy = (b_sidx != S_IDLE) & ~b_fire;
    assign w_busy = ((w_sidx != S_IDLE) & ~w_fire) | b_busy;
    assign ar_fire = ar_req & sel_ar_ready & ~r_busy;
    assign aw_fire = aw_req & sel_aw_ready & ~w_busy;
    assign w_fire = sel_w_valid & sel_w_ready & ~b_busy;

    always_comb begin
        for (int i = 0; i < MST; i++) begin
            o_ar_ready[i] = (ar_midx == MW'(i)) & sel_ar_ready & ~r_busy;
            o_aw_ready[i] = (aw_midx == MW'(i)) & sel_aw_ready & ~w_busy;
            o_w_ready[i] = (w_midx == MW'(i)) & sel_w_ready & ~b_busy;
            o_r_valid[i] = (r_midx == MW'(i)) & sel_r_valid;
            o_b_valid[i] = (b_midx == MW'(i)) & sel_b_valid;
            o_r_data[i] = sel_r_data;   // Payload broadcast, valid picks the owner
            o_r_resp[i] = sel_r_resp;
            o_b_resp[i] = sel_b_resp;
        end
        for (int j = 0; j <= SLV; j++) begin
            o_s_ar_valid[j] = (ar_sidx == SW'(j)) & ar_req & ~r_busy;
            o_s_aw_valid[j] = (aw_sidx == SW'(j)) & aw_req & ~w_busy;
            o_s_w_valid[j] = (w_sidx == SW'(j)) & sel_w_valid & ~b_busy;
            o_s_r_ready[j] = (r_sidx == SW'(j)) & sel_r_ready;
            o_s_b_ready[j] = (b_sidx == SW'(j)) & sel_b_ready;
            o_s_ar_addr[j] = ar_addr;
            o_s_aw_addr[j] = aw_addr;
            o_s_w_data[j] = sel_w_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_midx <= M_IDLE;
            r_sidx <= S_IDLE;
            w_midx <= M_IDLE;
            w_sidx <= S_IDLE;
            b_midx <= M_IDLE;
            b_sidx <= S_IDLE;
        end else begin
            if (ar_fire) begin
                r_midx <= ar_midx;
                r_sidx <= ar_sidx;
            end else if (r_fire) begin
                r_midx <= M_IDLE;
                r_sidx <= S_IDLE;
            end
            if (aw_fire) begin
                w_midx <= aw_midx;
                w_sidx <= aw_sidx;
            end else if (w_fire) begin
                w_midx <= M_IDLE;
                w_sidx <= S_IDLE;
            end
            // Write data hands its route over to the response
            if (w_fire) begin
                b_midx <= w_midx;
                b_sidx <= w_sidx;
            end else if (b_fire) begin
                b_midx <= M_IDLE;
                b_sidx <= S_IDLE;
            end
        end
    end

endmodule

//--- rtl/bus_err_slave.sv
// Default slave that completes every read and write with a decode error
module bus_err_slave (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_ar_valid,
    input  logic [bus_pkg::ADDR_BITS-1:0] i_ar_addr,
    output logic                          o_ar_ready,
    output logic                          o_r_valid,
    output logic [bus_pkg::DATA_BITS-1:0] o_r_data,
    output logic [1:0]                    o_r_resp,
    input  logic                          i_r_ready,
    input  logic                          i_aw_valid,
    input  logic [bus_pkg::ADDR_BITS-1:0] i_aw_addr,
    output logic                          o_aw_ready,
    input  logic                          i_w_valid,
    input  logic [bus_pkg::DATA_BITS-1:0] i_w_data,
    output logic                          o_w_ready,
    output logic                          o_b_valid,
    output logic [1:0]                    o_b_resp,
    input  logic                          i_b_ready
);

    logic rd_pend;
    bus_pkg::slv_state_e wr_state;

    assign o_ar_ready = ~rd_pend;
    assign o_r_valid = rd_pend;
    assign o_r_data = '1;   // Nothing behind this slot
    assign o_r_resp = bus_pkg::RESP_DECERR;
    assign o_aw_ready = (wr_state == bus_pkg::ST_IDLE);
    assign o_w_ready = (wr_state == bus_pkg::ST_WDATA);
    assign o_b_valid = (wr_state == bus_pkg::ST_BRESP);
    assign o_b_resp = bus_pkg::RESP_DECERR;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_pend <= 1'b0;
            wr_state <= bus_pkg::ST_IDLE;
        end else begin
            if (i_ar_valid && !rd_pend) rd_pend <= 1'b1;
            else if (i_r_ready) rd_pend <= 1'b0;
            case (wr_state)
                bus_pkg::ST_IDLE:  if (i_aw_valid) wr_state <= bus_pkg::ST_WDATA;
                bus_pkg::ST_WDATA: if (i_w_valid) wr_state <= bus_pkg::ST_BRESP;
                default:           if (i_b_ready) wr_state <= bus_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/bus_ram_slave.sv
// Single-beat RAM slave with independent read and write response paths
module bus_ram_slave #(
    parameter int RAM_WORDS = 256
) (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_ar_valid,
    input  logic [bus_pkg::ADDR_BITS-1:0] i_ar_addr,
    output logic                          o_ar_ready,
    output logic                          o_r_valid,
    output logic [bus_pkg::DATA_BITS-1:0] o_r_data,
    output logic [1:0]                    o_r_resp,
    input  logic                          i_r_ready,
    input  logic                          i_aw_valid,
    input  logic [bus_pkg::ADDR_BITS-1:0] i_aw_addr,
    output logic                          o_aw_ready,
    input  logic                          i_w_valid,
    input  logic [bus_pkg::DATA_BITS-1:0] i_w_data,
    output logic                          o_w_ready,
    output logic                          o_b_valid,
    output logic [1:0]                    o_b_resp,
    input  logic                          i_b_ready
);

    localparam int IDX_BITS = $clog2(RAM_WORDS);

    logic [bus_pkg::DATA_BITS-1:0] mem [RAM_WORDS];
    logic rd_pend;                              // Read data waiting for r_ready
    logic [bus_pkg::DATA_BITS-1:0] rd_data;
    bus_pkg::slv_state_e wr_state;
    logic [IDX_BITS-1:0] wr_idx;

    assign o_ar_ready = ~rd_pend;
    assign o_r_valid = rd_pend;
    assign o_r_data = rd_data;
    assign o_r_resp = bus_pkg::RESP_OKAY;
    assign o_aw_ready = (wr_state == bus_pkg::ST_IDLE);
    assign o_w_ready = (wr_state == bus_pkg::ST_WDATA);
    assign o_b_valid = (wr_state == bus_pkg::ST_BRESP);
    assign o_b_resp = bus_pkg::RESP_OKAY;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_pend <= 1'b0;
            wr_state <= bus_pkg::ST_IDLE;
        end else begin
            if (i_ar_valid && !rd_pend) rd_pend <= 1'b1;
            else if (i_r_ready) rd_pend <= 1'b0;
            case (wr_state)
                bus_pkg::ST_IDLE:  if (i_aw_valid) wr_state <= bus_pkg::ST_WDATA;
                bus_pkg::ST_WDATA: if (i_w_valid) wr_state <= bus_pkg::ST_BRESP;
                default:           if (i_b_ready) wr_state <= bus_pkg::ST_IDLE;
            endcase
        end
    end

    // Word index taken from the bits below the 1 KB window
    always_ff @(posedge i_clk) begin
        if (i_ar_valid && !rd_pend) begin
            rd_data <= mem[i_ar_addr[IDX_BITS+1:2]];
        end
        if (i_aw_valid && wr_state == bus_pkg::ST_IDLE) begin
            wr_idx <= i_aw_addr[IDX_BITS+1:2];
        end
        if (i_w_valid && wr_state == bus_pkg::ST_WDATA) begin
            mem[wr_idx] <= i_w_data;
        end
    end

endmodule

//--- rtl/bus_sys.sv
// Bus system top: crossbar with two RAM slaves and the decode-error default slave
module bus_sys #(
    parameter int RAM_WORDS = 256
) (
    input  logic                                                  i_clk,
    input  logic                                                  i_nrst,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_ar_valid,
    input  logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::ADDR_BITS-1:0] i_ar_addr,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_ar_ready,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_r_valid,
    output logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::DATA_BITS-1:0] o_r_data,
    output logic [bus_pkg::MST_TOTAL-1:0][1:0]                    o_r_resp,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_r_ready,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_aw_valid,
    input  logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::ADDR_BITS-1:0] i_aw_addr,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_aw_ready,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_w_valid,
    input  logic [bus_pkg::MST_TOTAL-1:0][bus_pkg::DATA_BITS-1:0] i_w_data,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_w_ready,
    output logic [bus_pkg::MST_TOTAL-1:0]                         o_b_valid,
    output logic [bus_pkg::MST_TOTAL-1:0][1:0]                    o_b_resp,
    input  logic [bus_pkg::MST_TOTAL-1:0]                         i_b_ready
);

    localparam int SLV = bus_pkg::SLV_TOTAL;

    // Slave-side bundles, slot SLV is the error slave
    logic [SLV:0] s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
    logic [SLV:0] s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
    logic [SLV:0] s_b_valid, s_b_ready;
    logic [SLV:0][bus_pkg::ADDR_BITS-1:0] s_ar_addr, s_aw_addr;
    logic [SLV:0][bus_pkg::DATA_BITS-1:0] s_r_data, s_w_data;
    logic [SLV:0][1:0] s_r_resp, s_b_resp;

    bus_xbar u_xbar (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_ar_valid(i_ar_valid), .i_ar_addr(i_ar_addr), .o_ar_ready(o_ar_ready),
        .o_r_valid(o_r_valid), .o_r_data(o_r_data), .o_r_resp(o_r_resp),
        .i_r_ready(i_r_ready),
        .i_aw_valid(i_aw_valid), .i_aw_addr(i_aw_addr), .o_aw_ready(o_aw_ready),
        .i_w_valid(i_w_valid), .i_w_data(i_w_data), .o_w_ready(o_w_ready),
        .o_b_valid(o_b_valid), .o_b_resp(o_b_resp), .i_b_ready(i_b_ready),
        .o_s_ar_valid(s_ar_valid), .o_s_ar_addr(s_ar_addr), .i_s_ar_ready(s_ar_ready),
        .i_s_r_valid(s_r_valid), .i_s_r_data(s_r_data), .i_s_r_resp(s_r_resp),
        .o_s_r_ready(s_r_ready),
        .o_s_aw_valid(s_aw_valid), .o_s_aw_addr(s_aw_addr), .i_s_aw_ready(s_aw_ready),
        .o_s_w_valid(s_w_valid), .o_s_w_data(s_w_data), .i_s_w_ready(s_w_ready),
        .i_s_b_valid(s_b_valid), .i_s_b_resp(s_b_resp), .o_s_b_ready(s_b_ready)
    );

    for (genvar s = 0; s < SLV; s++) begin : g_ram
        bus_ram_slave #(
            .RAM_WORDS(RAM_WORDS)
        ) u_ram (
            .i_clk(i_clk), .i_nrst(i_nrst),
            .i_ar_valid(s_ar_valid[s]), .i_ar_addr(s_ar_addr[s]),
            .o_ar_ready(s_ar_ready[s]),
            .o_r_valid(s_r_valid[s]), .o_r_data(s_r_data[s]), .o_r_resp(s_r_resp[s]),
            .i_r_ready(s_r_ready[s]),
            .i_aw_valid(s_aw_valid[s]), .i_aw_addr(s_aw_addr[s]),
            .o_aw_ready(s_aw_ready[s]),
            .i_w_valid(s_w_valid[s]), .i_w_data(s_w_data[s]), .o_w_ready(s_w_ready[s]),
            .o_b_valid(s_b_valid[s]), .o_b_resp(s_b_resp[s]), .i_b_ready(s_b_ready[s])
        );
    end

    bus_err_slave u_err (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_ar_valid(s_ar_valid[SLV]), .i_ar_addr(s_ar_addr[SLV]),
        .o_ar_ready(s_ar_ready[SLV]),
        .o_r_valid(s_r_valid[SLV]), .o_r_data(s_r_data[SLV]), .o_r_resp(s_r_resp[SLV]),
        .i_r_ready(s_r_ready[SLV]),
        .i_aw_valid(s_aw_valid[SLV]), .i_aw_addr(s_aw_addr[SLV]),
        .o_aw_ready(s_aw_ready[SLV]),
        .i_w_valid(s_w_valid[SLV]), .i_w_data(s_w_data[SLV]), .o_w_ready(s_w_ready[SLV]),
        .o_b_valid(s_b_valid[SLV]), .o_b_resp(s_b_resp[SLV]), .i_b_ready(s_b_ready[SLV])
    );

endmodule

//--- verif/bus_sys_tb.sv
// Table-driven testbench for the bus system with single-beat reads and writes from two masters
module bus_sys_tb;

    localparam int ROWS = 24;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES = 3;
    localparam int TIMEOUT_CYCLES = ROWS * 40;
    localparam int MST = bus_pkg::MST_TOTAL;
    localparam int AW = bus_pkg::ADDR_BITS;
    localparam int DW = bus_pkg::DATA_BITS;

    typedef enum logic [1:0] {OP_RD, OP_WR, OP_RD_PAIR, OP_WR_PAIR} op_e;
    typedef struct packed {
        op_e op;
        logic mst;          // Expected winner on paired rows
        logic [AW-1:0] addr;
        logic hold;         // Response back-pressure
    } row_t;

    logic i_clk;
    logic i_nrst;
    logic [MST-1:0] i_ar_valid, o_ar_ready, o_r_valid, i_r_ready;
    logic [MST-1:0] i_aw_valid, o_aw_ready, i_w_valid, o_w_ready, o_b_valid, i_b_ready;
    logic [MST-1:0][AW-1:0] i_ar_addr, i_aw_addr;
    logic [MST-1:0][DW-1:0] o_r_data, i_w_data;
    logic [MST-1:0][1:0] o_r_resp, o_b_resp;
    logic [31:0] lfsr = 32'hb0a9_4a9e;
    logic [DW-1:0] ref_mem [logic [AW-3:0]];   // Keyed by word address
    int unsigned cycle_cnt = 0;
    int err_cnt = 0;
    int unsigned ar_seen [MST], r_seen [MST], aw_seen [MST], b_seen [MST];

    // Second master of a pair uses addr + 4
    row_t rows [ROWS] = '{
        '{OP_WR,      1'b0, 16'h0000, 1'b0},
        '{OP_RD,      1'b0, 16'h0000, 1'b0},
        '{OP_WR,      1'b1, 16'h0004, 1'b0},
        '{OP_RD,      1'b1, 16'h0004, 1'b0},
        '{OP_WR,      1'b0, 16'h1000, 1'b0},
        '{OP_RD,      1'b0, 16'h1000, 1'b0},
        '{OP_WR,      1'b1, 16'h13FC, 1'b0},
        '{OP_RD,      1'b1, 16'h13FC, 1'b0},
        '{OP_WR,      1'b0, 16'h0010, 1'b0},
        '{OP_WR,      1'b1, 16'h1010, 1'b0},   // Same offset in slave 1
        '{OP_RD,      1'b0, 16'h0010, 1'b0},
        '{OP_RD,      1'b1, 16'h1010, 1'b0},
        '{OP_WR,      1'b0, 16'h2000, 1'b0},   // Unmapped
        '{OP_RD,      1'b1, 16'h0400, 1'b0},   // Just past slave 0
        '{OP_RD,      1'b0, 16'h0000, 1'b0},
        '{OP_WR,      1'b1, 16'h17FC, 1'b0},   // Unmapped with word bits aliasing 0x13FC
        '{OP_WR_PAIR, 1'b1, 16'h0100, 1'b0},
        '{OP_RD_PAIR, 1'b1, 16'h0100, 1'b0},
        '{OP_WR_PAIR, 1'b1, 16'h1200, 1'b1},
        '{OP_RD_PAIR, 1'b1, 16'h1200, 1'b1},
        '{OP_WR,      1'b0, 16'h03FC, 1'b1},
        '{OP_RD,      1'b1, 16'h03FC, 1'b1},
        '{OP_RD_PAIR, 1'b1, 16'h8000, 1'b0},
        '{OP_RD,      1'b0, 16'h13FC, 1'b0}
    };

    bus_sys #(.RAM_WORDS(256)) dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Galois step for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [DW-1:0] rand_word();
        logic [DW-1:0] w;
        w = '0;
        for (int b = 0; b < DW; b++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[DW-2:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic logic is_mapped(input logic [AW-1:0] a);
        return (a < 16'h0400) || (a >= 16'h1000 && a < 16'h1400);
    endfunction

    task automatic read_check(input int m, input logic [AW-1:0] addr, input logic hold);
        logic [DW-1:0] exp_data;
        logic [1:0] exp_resp;
        logic [DW-1:0] got;
        exp_resp = is_mapped(addr) ? bus_pkg::RESP_OKAY : bus_pkg::RESP_DECERR;
        exp_data = is_mapped(addr) ? ref_mem[addr[AW-1:2]] : 32'hFFFF_FFFF;
        @(posedge i_clk);
        i_ar_valid[m] <= 1'b1;
        i_ar_addr[m] <= addr;
        @(negedge i_clk);
        while (!o_ar_ready[m]) @(negedge i_clk);
        ar_seen[m] = cycle_cnt;
        if (o_r_valid[m]) begin
            $display("r_valid already high in the ar fire cycle, master %0d", m);
            err_cnt++;
        end
        @(posedge i_clk);
        i_ar_valid[m] <= 1'b0;
        i_r_ready[m] <= ~hold;
        @(negedge i_clk);
        if (!o_r_valid[m]) begin
            $display("r_valid not high one cycle after ar fire, master %0d", m);
            err_cnt++;
        end
        while (!o_r_valid[m]) @(negedge i_clk);
        got = o_r_data[m];
        if (hold) begin
            repeat (HOLD_CYCLES) begin
                @(negedge i_clk);
                if (!o_r_valid[m] || o_r_data[m] != got) begin
                    $display("read response not held under back-pressure, master %0d", m);
                    err_cnt++;
                end
            end
            @(posedge i_clk);
            i_r_ready[m] <= 1'b1;
            @(negedge i_clk);
        end
        r_seen[m] = cycle_cnt;
        if (got != exp_data) begin
            $display("mismatch o_r_data[%0d] got 0x%08h exp 0x%08h", m, got, exp_data);
            err_cnt++;
        end
        if (o_r_resp[m] != exp_resp) begin
            $display("mismatch o_r_resp[%0d] got 0x%0h exp 0x%0h", m, o_r_resp[m], exp_resp);
            err_cnt++;
        end
        @(posedge i_clk);
        i_r_ready[m] <= 1'b0;
    endtask

    task automatic write_check(input int m, input logic [AW-1:0] addr,
                               input logic [DW-1:0] data, input logic hold);
        logic [1:0] exp_resp;
        logic [1:0] got;
        exp_resp = is_mapped(addr) ? bus_pkg::RESP_OKAY : bus_pkg::RESP_DECERR;
        if (is_mapped(addr)) ref_mem[addr[AW-1:2]] = data;
        @(posedge i_clk);
        i_aw_valid[m] <= 1'b1;
        i_aw_addr[m] <= addr;
        @(negedge i_clk);
        while (!o_aw_ready[m]) @(negedge i_clk);
        aw_seen[m] = cycle_cnt;
        @(posedge i_clk);
        i_aw_valid[m] <= 1'b0;
        i_w_valid[m] <= 1'b1;
        i_w_data[m] <= data;
        @(negedge i_clk);
        while (!o_w_ready[m]) @(negedge i_clk);
        @(posedge i_clk);
        i_w_valid[m] <= 1'b0;
        i_b_ready[m] <= ~hold;
        @(negedge i_clk);
        while (!o_b_valid[m]) @(negedge i_clk);
        got = o_b_resp[m];
        if (hold) begin
            repeat (HOLD_CYCLES) begin
                @(negedge i_clk);
                if (!o_b_valid[m] || o_b_resp[m] != got) begin
                    $display("write response not held under back-pressure, master %0d", m);
                    err_cnt++;
                end
            end
            @(posedge i_clk);
            i_b_ready[m] <= 1'b1;
            @(negedge i_clk);
        end
        b_seen[m] = cycle_cnt;
        if (got != exp_resp) begin
            $display("mismatch o_b_resp[%0d] got 0x%0h exp 0x%0h", m, got, exp_resp);
            err_cnt++;
        end
        @(posedge i_clk);
        i_b_ready[m] <= 1'b0;
    endtask

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the table did not complete", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int win;
        int lose;
        logic [DW-1:0] d_win, d_lose;
        i_nrst <= 1'b0;
        i_ar_valid <= '0;
        i_ar_addr <= '0;
        i_r_ready <= '0;
        i_aw_valid <= '0;
        i_aw_addr <= '0;
        i_w_valid <= '0;
        i_w_data <= '0;
        i_b_ready <= '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(negedge i_clk);
        if (o_r_valid != '0 || o_b_valid != '0 || o_w_ready != '0) begin
            $display("a response valid or w_ready is high after reset");
            err_cnt++;
        end
        for (int i = 0; i < ROWS; i++) begin
            win = int'(rows[i].mst);
            lose = 1 - win;
            case (rows[i].op)
                OP_RD: read_check(win, rows[i].addr, rows[i].hold);
                OP_WR: write_check(win, rows[i].addr, rand_word(), rows[i].hold);
                OP_RD_PAIR: begin
                    fork
                        read_check(win, rows[i].addr, rows[i].hold);
                        read_check(lose, rows[i].addr + 16'h4, 1'b0);
                    join
                    // Loser may only start once the winner's read data has gone
                    if (ar_seen[win] >= ar_seen[lose] || ar_seen[lose] < r_seen[win]) begin
                        $display("read grant order wrong in row %0d", i);
                        err_cnt++;
                    end
                end
                default: begin
                    d_win = rand_word();
                    d_lose = rand_word();
                    fork
                        write_check(win, rows[i].addr, d_win, rows[i].hold);
                        write_check(lose, rows[i].addr + 16'h4, d_lose, 1'b0);
                    join
                    if (aw_seen[win] >= aw_seen[lose] || aw_seen[lose] < b_seen[win]) begin
                        $display("write grant order wrong in row %0d", i);
                        err_cnt++;
                    end
                end
            endcase
        end
        $display("rows run %0d, errors %0d", ROWS, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- bus_sys.f
rtl/bus_pkg.sv
rtl/bus_xbar.sv
rtl/bus_err_slave.sv
rtl/bus_ram_slave.sv
rtl/bus_sys.sv
verif/bus_sys_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bus_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=bus_sys_sim

verilator --binary --timing -f bus_sys.f --top-module bus_sys_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
